//--- src/byteOutputQueue.sv
`timescale 1ns/1ps

module byteOutputQueue (
    input  logic clk48_i,
    input  logic rxRST_i,
    input  logic pushByte_i,
    input  logic [7:0] byteData_i,
    input  logic isPacketByte_i,
    input  logic eopSeen_i,
    input  logic crc16Packet_i,
    input  logic dropPacket_i,
    input  logic rxAcceptNewData_i,
    output logic [7:0] rxData_o,
    output logic rxDataValid_o,
    output logic rxIsLastByte_o,
    output logic keepPacket_o
);

    // Three byte delay line ahead of the output register
    logic [7:0] slotNew;
    logic [7:0] slotMid;
    logic [7:0] slotOld;

    // Bit 3 tags rxData_o, bit 0 tags slotNew
    logic [3:0] dataTags;
    logic [3:0] nextTags;

    logic flushing;
    logic byteMissed;
    logic handshake;
    logic propagate;

    assign rxDataValid_o = dataTags[3];
    // Last byte when nothing tagged follows
    assign rxIsLastByte_o = dataTags[3] && !dataTags[2];
    assign keepPacket_o = !(dropPacket_i || byteMissed);

    assign handshake = rxDataValid_o && rxAcceptNewData_i;
    // After EOP the line moves on each transfer or while the output is empty
    assign propagate = pushByte_i || (flushing && (handshake || !rxDataValid_o));

    always_comb begin
        nextTags = dataTags;
        if (propagate) begin
            nextTags = {dataTags[2:0], pushByte_i && isPacketByte_i};
        end else if (handshake) begin
            nextTags[3] = 1'b0;
        end
        // Two newest bytes are the CRC16 field
        if (eopSeen_i && crc16Packet_i) begin
            nextTags[1:0] = 2'b00;
        end
    end

    always_ff @(posedge clk48_i) begin
        if (rxRST_i) begin
            dataTags <= '0;
            flushing <= 1'b0;
            byteMissed <= 1'b0;
        end else begin
            dataTags <= nextTags;
            // Flush until no tagged byte waits behind the output
            flushing <= (flushing || eopSeen_i) && (|nextTags[2:0]);

            if (pushByte_i) begin
                if (dataTags == 4'b0000) begin
                    // Empty queue, first byte of a new packet
                    byteMissed <= 1'b0;
                end else if (dataTags[3] && !handshake) begin
                    // Output byte overwritten before the backend took it
                    byteMissed <= 1'b1;
                end
            end
        end
    end

    // Payload path
    always_ff @(posedge clk48_i) begin
        if (propagate) begin
            slotNew <= byteData_i;
            slotMid <= slotNew;
            slotOld <= slotMid;
            rxData_o <= slotOld;
        end
    end

endmodule

//--- src/crcChecker.sv
`timescale 1ns/1ps

module crcChecker
    import usbRxPkg::*;
(
    input  logic clk48_i,
    input  logic rxRST_i,
    input  logic crcInit_i,
    input  logic useCrc16_i,
    input  logic dataBit_i,
    input  logic bitValid_i,
    output logic crcOk_o
);

    // CRC5 lives in the low five bits
    logic [15:0] crcReg;
    logic feedback16;
    logic feedback5;

    assign feedback16 = dataBit_i ^ crcReg[15];
    assign feedback5 = dataBit_i ^ crcReg[4];

    always_ff @(posedge clk48_i) begin
        if (rxRST_i) begin
            crcReg <= '1;
        end else if (crcInit_i) begin
            // Preset to all ones before the first covered bit
            crcReg <= '1;
        end else if (bitValid_i) begin
            if (useCrc16_i) begin
                crcReg <= {crcReg[14:0], 1'b0} ^ (feedback16 ? crc16Poly : 16'h0000);
            end else begin
                crcReg[4:0] <= {crcReg[3:0], 1'b0} ^ (feedback5 ? crc5Poly : 5'b00000);
            end
        end
    end

    // Residual compare, valid once the CRC field itself has been shifted in
    assign crcOk_o = useCrc16_i ? (crcReg == crc16Residual) : (crcReg[4:0] == crc5Residual);

endmodule

//--- src/nrziUnstuffer.sv
`timescale 1ns/1ps

module nrziUnstuffer
    import usbRxPkg::*;
(
    input  logic clk48_i,
    input  logic rxRST_i,
    input  logic bitStrobe_i,
    input  logic dataInP_i,
    input  logic isValidDPSignal_i,
    usbRxBitIf.decodeMp bitIf
);

    // Last line sample, idle line is J
    logic prevSample;
    // Consecutive decoded ones since the last zero
    logic [2:0] onesCount;
    // Bits gathered in the current byte
    logic [2:0] bitCount;

    logic decodedBit;
    logic stuffedBit;
    logic [7:0] nextShift;

    // No transition on the line means a one
    assign decodedBit = (dataInP_i == prevSample);
    // After six ones the next bit is a stuffed zero
    assign stuffedBit = (onesCount == maxStuffRun);
    // LSB first, new bit enters at the top
    assign nextShift = {decodedBit, bitIf.byteData[7:1]};

    // ======================================================================
    // Control and strobes
    // ======================================================================
    always_ff @(posedge clk48_i) begin
        if (rxRST_i) begin
            prevSample <= 1'b1;
            onesCount <= '0;
            bitCount <= '0;
            bitIf.bitValid <= 1'b0;
            bitIf.byteFull <= 1'b0;
            bitIf.syncSeen <= 1'b0;
            bitIf.stuffError <= 1'b0;
            bitIf.lineError <= 1'b0;
        end else begin
            // Strobes last one clock
            bitIf.bitValid <= 1'b0;
            bitIf.byteFull <= 1'b0;
            bitIf.syncSeen <= 1'b0;
            bitIf.stuffError <= 1'b0;
            bitIf.lineError <= 1'b0;

            if (bitStrobe_i) begin
                prevSample <= dataInP_i;
                bitIf.lineError <= !isValidDPSignal_i;

                if (stuffedBit) begin
                    // Drop the stuffed bit, a one here breaks the rule
                    onesCount <= '0;
                    bitIf.stuffError <= decodedBit;
                end else begin
                    bitIf.bitValid <= 1'b1;
                    onesCount <= decodedBit ? onesCount + 3'd1 : 3'd0;
                    bitCount <= bitCount + 3'd1;
                    bitIf.byteFull <= (bitCount == 3'd7) && !bitIf.alignReset;
                    // Sliding window over the last eight bits
                    bitIf.syncSeen <= (nextShift == syncPattern);
                end
            end

            // Alignment restart wins over counting
            if (bitIf.alignReset) begin
                onesCount <= '0;
                bitCount <= '0;
            end
        end
    end

    // Payload shift register
    always_ff @(posedge clk48_i) begin
        if (bitStrobe_i && !stuffedBit) begin
            bitIf.byteData <= nextShift;
            bitIf.dataBit <= decodedBit;
        end
    end

endmodule

//--- src/packetControl.sv
`timescale 1ns/1ps

module packetControl
    import usbRxPkg::*;
(
    input  logic clk48_i,
    input  logic rxRST_i,
    input  logic eopDetected_i,
    usbRxBitIf.executeMp bitIf,
    input  logic crcOk_i,
    output logic crcInit_o,
    output logic useCrc16_o,
    output logic pushByte_o,
    output logic isPacketByte_o,
    output logic eopSeen_o,
    output logic crc16Packet_o,
    output logic dropPacket_o
);

    rxState_t rxState;

    logic dropFlag;
    logic crc16Flag;
    // CRC status sampled after each byte, checked at EOP
    logic lastCrcOk;
    // CRC register has taken the last bit one clock after byteFull
    logic byteEndDly;

    logic inPacket;
    logic pidOk;
    logic signalError;

    assign inPacket = (rxState == getPid) || (rxState == getData);
    // Upper nibble carries the inverted PID
    assign pidOk = (bitIf.byteData[7:4] == ~bitIf.byteData[3:0]);
    assign signalError = bitIf.stuffError || bitIf.lineError;

    // Byte counting stays cleared until SYNC has been seen
    assign bitIf.alignReset = (rxState == waitSync);

    // PID bits are not covered by the CRC
    assign crcInit_o = (rxState == getPid);
    assign useCrc16_o = crc16Flag;

    assign pushByte_o = bitIf.byteFull && inPacket;
    assign isPacketByte_o = inPacket;
    assign eopSeen_o = eopDetected_i && inPacket;
    assign crc16Packet_o = crc16Flag;
    assign dropPacket_o = dropFlag;

    // ======================================================================
    // Receive FSM
    // ======================================================================
    always_ff @(posedge clk48_i) begin
        if (rxRST_i) begin
            rxState <= waitSync;
            dropFlag <= 1'b0;
            crc16Flag <= 1'b0;
            lastCrcOk <= 1'b1;
            byteEndDly <= 1'b0;
        end else begin
            byteEndDly <= bitIf.byteFull && (rxState == getData);

            unique case (rxState)
                waitSync: begin
                    // Drop flag of the previous packet holds until a new SYNC
                    if (bitIf.syncSeen) begin
                        rxState <= getPid;
                        dropFlag <= 1'b0;
                    end
                end
                getPid: begin
                    if (eopDetected_i) begin
                        // SYNC without a PID
                        dropFlag <= 1'b1;
                        rxState <= rstPhase;
                    end else if (bitIf.byteFull) begin
                        if (!pidOk) begin
                            dropFlag <= 1'b1;
                        end
                        // Only data packets carry CRC16
                        crc16Flag <= (bitIf.byteData[1:0] == pidDataMask);
                        rxState <= getData;
                    end
                end
                getData: begin
                    if (eopDetected_i) begin
                        if (!lastCrcOk) begin
                            dropFlag <= 1'b1;
                        end
                        rxState <= rstPhase;
                    end else if (byteEndDly) begin
                        lastCrcOk <= crcOk_i;
                    end
                end
                rstPhase: begin
                    // Handshake packets have no CRC and must pass
                    lastCrcOk <= 1'b1;
                    rxState <= waitSync;
                end
            endcase

            // Line errors between SYNC and EOP
            if (inPacket && signalError) begin
                dropFlag <= 1'b1;
            end
        end
    end

endmodule

//--- src/usbRx.sv
`timescale 1ns/1ps

module usbRx (
    input  logic clk48_i,
    input  logic rxRST_i,

    // Front end samples, one per bit strobe
    input  logic bitStrobe_i,
    input  logic dataInP_i,
    input  logic isValidDPSignal_i,
    input  logic eopDetected_i,

    // Backend byte interface
    input  logic rxAcceptNewData_i,
    output logic [7:0] rxData_o,
    output logic rxDataValid_o,
    output logic rxIsLastByte_o,
    output logic keepPacket_o
);

    // CRC control
    logic crcInit;
    logic useCrc16;
    logic crcOk;

    // Byte path to the output queue
    logic pushByte;
    logic isPacketByte;
    logic eopSeen;
    logic crc16Packet;
    logic dropPacket;

    usbRxBitIf bitIf ();

    // ======================================================================
    // Decode
    // ======================================================================
    nrziUnstuffer decode0 (
        .clk48_i          (clk48_i),
        .rxRST_i          (rxRST_i),
        .bitStrobe_i      (bitStrobe_i),
        .dataInP_i        (dataInP_i),
        .isValidDPSignal_i(isValidDPSignal_i),
        .bitIf            (bitIf.decodeMp)
    );

    crcChecker crc0 (
        .clk48_i   (clk48_i),
        .rxRST_i   (rxRST_i),
        .crcInit_i (crcInit),
        .useCrc16_i(useCrc16),
        .dataBit_i (bitIf.dataBit),
        .bitValid_i(bitIf.bitValid),
        .crcOk_o   (crcOk)
    );

    // Execute
    packetControl control0 (
        .clk48_i       (clk48_i),
        .rxRST_i       (rxRST_i),
        .eopDetected_i (eopDetected_i),
        .bitIf         (bitIf.executeMp),
        .crcOk_i       (crcOk),
        .crcInit_o     (crcInit),
        .useCrc16_o    (useCrc16),
        .pushByte_o    (pushByte),
        .isPacketByte_o(isPacketByte),
        .eopSeen_o     (eopSeen),
        .crc16Packet_o (crc16Packet),
        .dropPacket_o  (dropPacket)
    );

    // Result
    byteOutputQueue queue0 (
        .clk48_i          (clk48_i),
        .rxRST_i          (rxRST_i),
        .pushByte_i       (pushByte),
        .byteData_i       (bitIf.byteData),
        .isPacketByte_i   (isPacketByte),
        .eopSeen_i        (eopSeen),
        .crc16Packet_i    (crc16Packet),
        .dropPacket_i     (dropPacket),
        .rxAcceptNewData_i(rxAcceptNewData_i),
        .rxData_o         (rxData_o),
        .rxDataValid_o    (rxDataValid_o),
        .rxIsLastByte_o   (rxIsLastByte_o),
        .keepPacket_o     (keepPacket_o)
    );

endmodule

//--- src/usbRxBitIf.sv
`timescale 1ns/1ps

interface usbRxBitIf;

    // Decoded bit stream, one pulse per unstuffed bit
    logic dataBit;
    logic bitValid;

    // Byte assembly
    logic [7:0] byteData;
    logic byteFull;

    // Line events, all single cycle strobes
    logic syncSeen;
    logic stuffError;
    logic lineError;

    // Held by the FSM while bytes must not be counted
    logic alignReset;

    modport decodeMp (
        output dataBit, bitValid, byteData, byteFull, syncSeen, stuffError, lineError,
        input  alignReset
    );

    modport executeMp (
        input  dataBit, bitValid, byteData, byteFull, syncSeen, stuffError, lineError,
        output alignReset
    );

endinterface

//--- src/usbRxPkg.sv
package usbRxPkg;

    // ======================================================================
    // Line level constants
    // ======================================================================

    // SYNC after NRZI decoding, shifted in LSB first (KJKJKJKK)
    localparam logic [7:0] syncPattern = 8'h80;

    // PID bits 1:0 of DATA0, DATA1, DATA2 and MDATA
    localparam logic [1:0] pidDataMask = 2'b11;

    // Ones in a row before the transmitter inserts a zero
    localparam logic [2:0] maxStuffRun = 3'd6;

    // ======================================================================
    // CRC constants
    // ======================================================================

    // x^5 + x^2 + 1
    localparam logic [4:0] crc5Poly = 5'b00101;
    // x^16 + x^15 + x^2 + 1
    localparam logic [15:0] crc16Poly = 16'h8005;

    // Register contents after a packet with a correct CRC has been shifted in
    localparam logic [4:0] crc5Residual = 5'b01100;
    localparam logic [15:0] crc16Residual = 16'h800D;

    // Receive FSM states
    typedef enum logic [1:0] {
        waitSync = 2'd0,
        getPid   = 2'd1,
        getData  = 2'd2,
        rstPhase = 2'd3
    } rxState_t;

endpackage

//--- tb/usbRxChecker.sv
`timescale 1ns/1ps

module usbRxChecker (
    input  logic clk48_i,
    input  logic rxRST_i,
    input  logic [7:0] rxData_i,
    input  logic rxDataValid_i,
    input  logic rxIsLastByte_i,
    input  logic keepPacket_i,
    input  logic rxAcceptNewData_i
);

    // Expectation of the packet in flight
    string expName;
    bit expKeep;
    bit expCheckBytes;
    bit expActive = 1'b0;
    logic [7:0] expBytes[$];
    logic [7:0] gotBytes[$];

    int doneCount = 0;
    int passCount = 0;
    int failCount = 0;
    // Bytes seen with no packet expected
    int strayCount = 0;

    task startPacket(input string name, input bit keep, input bit checkBytes);
        expName = name;
        expKeep = keep;
        expCheckBytes = checkBytes;
        expBytes.delete();
        gotBytes.delete();
        expActive = 1'b1;
    endtask

    task addByte(input logic [7:0] b);
        expBytes.push_back(b);
    endtask

    task finishPacket(input logic keepSeen);
        int errors;
        int i;
        errors = 0;
        if (expCheckBytes) begin
            if (gotBytes.size() != expBytes.size()) begin
                $display("ERROR %s byte count expected %0d actual %0d",
                         expName, expBytes.size(), gotBytes.size());
                errors++;
            end
            for (i = 0; i < gotBytes.size() && i < expBytes.size(); i++) begin
                if (gotBytes[i] !== expBytes[i]) begin
                    $display("ERROR %s byte %0d expected %02h actual %02h",
                             expName, i, expBytes[i], gotBytes[i]);
                    errors++;
                end
            end
        end
        if (keepSeen !== expKeep) begin
            $display("ERROR %s keep expected %0d actual %0d", expName, expKeep, keepSeen);
            errors++;
        end
        if (errors == 0) begin
            $display("%s: passed, %0d bytes", expName, gotBytes.size());
            passCount++;
        end else begin
            $display("%s: failed with %0d errors", expName, errors);
            failCount++;
        end
        doneCount++;
        expActive = 1'b0;
    endtask

    // Transfer happens on a clock edge with valid and accept high
    always @(posedge clk48_i) begin
        if (!rxRST_i && rxDataValid_i && rxAcceptNewData_i) begin
            if (!expActive) begin
                $display("Output byte %02h arrived while no packet was expected", rxData_i);
                strayCount++;
            end else begin
                gotBytes.push_back(rxData_i);
                if (rxIsLastByte_i) begin
                    finishPacket(keepPacket_i);
                end
            end
        end
    end

endmodule

//--- tb/usbRxTb.sv
`timescale 1ns/1ps

module usbRxTb;

    localparam int maxPayload = 16;
    localparam int numTests = 12;
    // Worst case line bits per packet with stuffing overhead
    localparam int maxPacketBits = (maxPayload + 6) * 8 * 7 / 6;
    localparam int timeoutLimit = numTests * maxPacketBits * 4 + 2000;

    logic clk48_i;
    logic rxRST_i;
    logic bitStrobe_i;
    logic dataInP_i;
    logic isValidDPSignal_i;
    logic eopDetected_i;
    logic rxAcceptNewData_i;
    logic [7:0] rxData_o;
    logic rxDataValid_o;
    logic rxIsLastByte_o;
    logic keepPacket_o;

    // Unstuffed packet bits after SYNC, in line order
    bit pktBits[$];
    logic lineLevel;
    bit holdAccept;
    int cycleCount = 0;
    int testsStarted = 0;
    int k;

    usbRx dut0 (.*);

    usbRxChecker chk0 (
        .clk48_i          (clk48_i),
        .rxRST_i          (rxRST_i),
        .rxData_i         (rxData_o),
        .rxDataValid_i    (rxDataValid_o),
        .rxIsLastByte_i   (rxIsLastByte_o),
        .keepPacket_i     (keepPacket_o),
        .rxAcceptNewData_i(rxAcceptNewData_i)
    );

    initial begin
        clk48_i = 1'b0;
        forever #10 clk48_i = ~clk48_i;
    end

    // Backend takes bytes on most cycles
    initial begin
        forever begin
            @(negedge clk48_i);
            if (holdAccept || rxRST_i) begin
                rxAcceptNewData_i = 1'b0;
            end else begin
                rxAcceptNewData_i = ($urandom % 4) != 0;
            end
        end
    end

    always @(posedge clk48_i) begin
        cycleCount++;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout: the run went past %0d cycles before all tests ended",
                     timeoutLimit);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ======================================================================
    // Packet builders
    // ======================================================================
    task automatic appendByte(input logic [7:0] b);
        int i;
        for (i = 0; i < 8; i++) begin
            pktBits.push_back(b[i]);
        end
    endtask

    // USB CRC5, preset ones, inverted result sent MSB first
    task automatic appendCrc5(input int startIdx);
        logic [4:0] c;
        logic fb;
        int i;
        c = 5'h1F;
        for (i = startIdx; i < pktBits.size(); i++) begin
            fb = pktBits[i] ^ c[4];
            c = {c[3:0], 1'b0};
            if (fb) c = c ^ 5'h05;
        end
        c = ~c;
        for (i = 4; i >= 0; i--) begin
            pktBits.push_back(c[i]);
        end
    endtask

    // USB CRC16 over the payload
    task automatic appendCrc16(input int startIdx);
        logic [15:0] c;
        logic fb;
        int i;
        c = 16'hFFFF;
        for (i = startIdx; i < pktBits.size(); i++) begin
            fb = pktBits[i] ^ c[15];
            c = {c[14:0], 1'b0};
            if (fb) c = c ^ 16'h8005;
        end
        c = ~c;
        for (i = 15; i >= 0; i--) begin
            pktBits.push_back(c[i]);
        end
    endtask

    task automatic buildData(input logic [7:0] pid, input int len);
        pktBits.delete();
        appendByte(pid);
        repeat (len) appendByte($urandom);
        appendCrc16(8);
    endtask

    // Address and endpoint are 11 random bits
    task automatic buildToken(input logic [7:0] pid);
        pktBits.delete();
        appendByte(pid);
        repeat (11) pktBits.push_back($urandom % 2);
        appendCrc5(8);
    endtask

    task automatic buildHandshake(input logic [7:0] pid);
        pktBits.delete();
        appendByte(pid);
    endtask

    // Model output: every whole byte, data packets lose their CRC16
    task automatic expectPacket(input string name, input bit isData, input bit keep,
                                input bit checkBytes);
        int nBytes;
        logic [7:0] b;
        int i;
        int j;
        nBytes = pktBits.size() / 8;
        if (isData) nBytes -= 2;
        chk0.startPacket(name, keep, checkBytes);
        for (i = 0; i < nBytes; i++) begin
            for (j = 0; j < 8; j++) begin
                b[j] = pktBits[8 * i + j];
            end
            chk0.addByte(b);
        end
    endtask

    // ======================================================================
    // Line encoder
    // ======================================================================
    // One strobe every four clocks
    task automatic driveBit(input logic level, input logic pairValid);
        @(negedge clk48_i);
        bitStrobe_i = 1'b1;
        dataInP_i = level;
        isValidDPSignal_i = pairValid;
        @(negedge clk48_i);
        bitStrobe_i = 1'b0;
        isValidDPSignal_i = 1'b1;
        repeat (2) @(negedge clk48_i);
    endtask

    // NRZI, a zero toggles the line
    task automatic encodeBit(input bit b, input logic pairValid);
        if (!b) lineLevel = ~lineLevel;
        driveBit(lineLevel, pairValid);
    endtask

    task automatic sendPacket(input int rawOnesAt, input int badLineBit);
        int onesRun;
        int i;
        onesRun = 0;
        // SYNC, seven zeros and a one
        repeat (7) encodeBit(1'b0, 1'b1);
        encodeBit(1'b1, 1'b1);
        for (i = 0; i < pktBits.size(); i++) begin
            if (i == rawOnesAt) begin
                // Unstuffed run of seven ones
                repeat (7) encodeBit(1'b1, 1'b1);
                onesRun = 0;
            end
            encodeBit(pktBits[i], i != badLineBit);
            onesRun = pktBits[i] ? onesRun + 1 : 0;
            if (onesRun == 6) begin
                encodeBit(1'b0, 1'b1);
                onesRun = 0;
            end
        end
        @(negedge clk48_i);
        eopDetected_i = 1'b1;
        @(negedge clk48_i);
        eopDetected_i = 1'b0;
    endtask

    task automatic runTest(input string name, input bit isData, input bit keep,
                           input bit checkBytes, input int rawOnesAt,
                           input int badLineBit, input bit backPressure);
        expectPacket(name, isData, keep, checkBytes);
        holdAccept = backPressure;
        sendPacket(rawOnesAt, badLineBit);
        holdAccept = 1'b0;
        testsStarted++;
        wait (chk0.doneCount == testsStarted);
        repeat (8) @(negedge clk48_i);
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        void'($urandom(29));
        rxRST_i = 1'b1;
        bitStrobe_i = 1'b0;
        dataInP_i = 1'b1;
        isValidDPSignal_i = 1'b1;
        eopDetected_i = 1'b0;
        rxAcceptNewData_i = 1'b0;
        holdAccept = 1'b0;
        lineLevel = 1'b1;
        repeat (4) @(negedge clk48_i);
        rxRST_i = 1'b0;
        repeat (4) @(negedge clk48_i);

        buildData(8'hC3, 1 + $urandom % maxPayload);
        runTest("data0 clean", 1, 1, 1, -1, -1, 0);
        buildData(8'h4B, 1 + $urandom % maxPayload);
        runTest("data1 clean", 1, 1, 1, -1, -1, 0);
        buildToken(8'hE1);
        runTest("out token", 0, 1, 1, -1, -1, 0);
        buildToken(8'h69);
        runTest("in token", 0, 1, 1, -1, -1, 0);
        buildHandshake(8'hD2);
        runTest("ack handshake", 0, 1, 1, -1, -1, 0);

        buildData(8'hC3, 1 + $urandom % maxPayload);
        k = 8 + $urandom % (pktBits.size() - 24);
        pktBits[k] = !pktBits[k];
        runTest("data flipped bit", 1, 0, 1, -1, -1, 0);

        // Nibbles not complementary, low bits still mark data
        buildData(8'h53, 1 + $urandom % maxPayload);
        runTest("bad pid", 1, 0, 1, -1, -1, 0);

        buildData(8'h4B, 6);
        runTest("stuff error", 1, 0, 0, 12, -1, 0);
        buildToken(8'hE1);
        runTest("line error", 0, 0, 1, -1, 12, 0);

        buildData(8'hC3, maxPayload);
        runTest("back pressure", 1, 0, 0, -1, -1, 1);
        buildData(8'h4B, 1 + $urandom % maxPayload);
        runTest("after back pressure", 1, 1, 1, -1, -1, 0);
        buildHandshake(8'h5A);
        runTest("nak handshake", 0, 1, 1, -1, -1, 0);

        repeat (10) @(negedge clk48_i);
        $display("Tests run %0d, passed %0d, failed %0d, stray bytes %0d, assertion fails %0d",
                 chk0.doneCount, chk0.passCount, chk0.failCount, chk0.strayCount,
                 dut0.props0.assertFails);
        if (chk0.failCount == 0 && chk0.strayCount == 0 && chk0.doneCount == numTests
            && dut0.props0.assertFails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- tb/usbRx_props.sv
`timescale 1ns/1ps

module usbRxProps (
    input  logic clk48_i,
    input  logic rxRST_i,
    input  logic [7:0] rxData_i,
    input  logic rxDataValid_i,
    input  logic rxIsLastByte_i,
    input  logic rxAcceptNewData_i,
    input  logic pushByte_i
);

    // Count of failed assertions
    int assertFails = 0;

    // Output byte holds until taken
    // A push into a stalled queue overwrites it on purpose
    holdWhileStalled: assert property (@(posedge clk48_i) disable iff (rxRST_i)
        rxDataValid_i && !rxAcceptNewData_i && !pushByte_i |=> $stable(rxData_i))
    else begin
        $error("rxData_o changed while valid and not accepted");
        assertFails++;
    end

    // Last flag stays on a valid byte until the backend takes it
    lastHeldUntilTaken: assert property (@(posedge clk48_i) disable iff (rxRST_i)
        rxIsLastByte_i && !rxAcceptNewData_i && !pushByte_i
            |=> rxIsLastByte_i && rxDataValid_i)
    else begin
        $error("rxIsLastByte_o dropped or lost rxDataValid_o before the byte was taken");
        assertFails++;
    end

    // Queue is empty right after reset
    quietAfterReset: assert property (@(posedge clk48_i)
        rxRST_i |=> !rxDataValid_i && !rxIsLastByte_i)
    else begin
        $error("valid or last output high in the cycle after reset");
        assertFails++;
    end

endmodule

bind usbRx usbRxProps props0 (
    .clk48_i          (clk48_i),
    .rxRST_i          (rxRST_i),
    .rxData_i         (rxData_o),
    .rxDataValid_i    (rxDataValid_o),
    .rxIsLastByte_i   (rxIsLastByte_o),
    .rxAcceptNewData_i(rxAcceptNewData_i),
    .pushByte_i       (pushByte)
);

//--- usbRx.f
src/usbRxPkg.sv
src/usbRxBitIf.sv
src/nrziUnstuffer.sv
src/crcChecker.sv
src/packetControl.sv
src/byteOutputQueue.sv
src/usbRx.sv
tb/usbRx_props.sv
tb/usbRxChecker.sv
tb/usbRxTb.sv
